// File: filelist.f
rtl/dcachePkg.sv
rtl/dcacheCtrl.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/refillBuffer.sv
rtl/dcacheTop.sv
tests/memModel.sv
tests/tbDcache.sv

// File: rtl/dataStore.sv
module dataStore (
  input  logic                           clk,
  input  logic [dcachePkg::INDEX_W-1:0]  index_i,
  input  logic [dcachePkg::OFFSET_W-1:0] offset_i,
  input  dcachePkg::wayIdx_t             hitWay_i,
  input  dcachePkg::wayIdx_t             victimWay_i,
  input  logic                           storeEn_i,
  input  logic [dcachePkg::XLEN-1:0]     storeData_i,
  input  logic [dcachePkg::MASK_W-1:0]   storeMask_i,
  input  logic                           fill_i,
  input  logic [dcachePkg::LINE_W-1:0]   fillLine_i,
  output logic [dcachePkg::XLEN-1:0]     rdData_o,
  output logic [dcachePkg::LINE_W-1:0]   victimLine_o
);
  import dcachePkg::*;

  logic [LINE_W-1:0] lineArr [2][SETS];
  logic [LINE_W-1:0] hitLine;
  logic [1:0]        wordSel;
  logic [XLEN-1:0]   shiftData;
  logic [MASK_W-1:0] shiftMask;
  logic [XLEN-1:0]   bitMask;
  logic [XLEN-1:0]   oldWord;

  assign wordSel = offset_i[4:3];

  // align to the byte offset and drop overflow bytes off the top
  assign shiftData = storeData_i << {offset_i[2:0], 3'b000};
  assign shiftMask = storeMask_i << offset_i[2:0];

  always_comb begin
    for (int b = 0; b < MASK_W; b++) begin
      bitMask[b*8 +: 8] = {8{shiftMask[b]}};
    end
  end

  assign hitLine = lineArr[hitWay_i][index_i];
  assign oldWord = hitLine[wordSel*XLEN +: XLEN];

  always_ff @(posedge clk) begin
    if (fill_i) begin
      lineArr[victimWay_i][index_i] <= fillLine_i;
    end else if (storeEn_i) begin
      lineArr[hitWay_i][index_i][wordSel*XLEN +: XLEN] <=
        (oldWord & ~bitMask) | (shiftData & bitMask);
    end
  end

  assign rdData_o     = oldWord;
  assign victimLine_o = lineArr[victimWay_i][index_i];

endmodule

// File: rtl/dcacheCtrl.sv
module dcacheCtrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  dcachePkg::cpuReq_t          req_i,
  input  logic                        reqValid_i,
  output logic                        addrOk_o,
  output logic                        dataOk_o,
  output dcachePkg::cpuReq_t          reqLatch_o,
  input  logic [1:0]                  wayHit_i,
  input  logic                        victimDirty_i,
  input  logic [dcachePkg::TAG_W-1:0] victimTag_i,
  output dcachePkg::wayIdx_t          victimWay_o,
  output dcachePkg::wayIdx_t          hitWay_o,
  output logic                        storeEn_o,
  output logic                        fill_o,
  output logic                        refill_o,
  output logic                        rdValid_o,
  output logic [dcachePkg::ADDR_W-1:0] rdAddr_o,
  input  logic                        rdReady_i,
  input  logic                        rdLast_i,
  input  logic                        dataValid_i,
  output logic                        wrValid_o,
  output logic [dcachePkg::ADDR_W-1:0] wrAddr_o,
  input  logic                        wrReady_i
);
  import dcachePkg::*;

  cacheState_e        curState;
  cacheState_e        nextState;
  cpuReq_t            reqLatch;
  wayIdx_t            victimPtr;
  logic               cacheHit;
  logic [INDEX_W-1:0] index;

  assign index    = reqLatch.addr[OFFSET_W +: INDEX_W];
  assign cacheHit = |wayHit_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= Idle;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      Idle: begin
        if (reqValid_i) begin
          nextState = Compare;
        end
      end
      Compare: begin
        if (cacheHit) begin
          nextState = Idle;
        end else if (victimDirty_i) begin
          nextState = WriteBack;
        end else begin
          nextState = Miss;
        end
      end
      WriteBack: begin
        // victim must leave before the refill overwrites it
        if (wrReady_i) begin
          nextState = Miss;
        end
      end
      Miss: begin
        if (rdReady_i) begin
          nextState = Refill;
        end
      end
      Refill: begin
        if (dataValid_i && rdLast_i) begin
          nextState = Replace;
        end
      end
      Replace: begin
        nextState = Compare;
      end
      default: begin
        nextState = Idle;
      end
    endcase
  end

  // request held for the whole miss sequence
  always_ff @(posedge clk) begin
    if (curState == Idle && reqValid_i) begin
      reqLatch <= req_i;
    end
  end

  // one pointer shared by all sets
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimPtr <= 1'b0;
    end else if (curState == Replace) begin
      victimPtr <= ~victimPtr;
    end
  end

  assign addrOk_o   = (curState == Idle);
  assign dataOk_o   = (curState == Compare) && cacheHit;
  assign storeEn_o  = (curState == Compare) && cacheHit && reqLatch.write;
  assign fill_o     = (curState == Replace);
  assign refill_o   = (curState == Refill);
  assign rdValid_o  = (curState == Miss);
  assign wrValid_o  = (curState == WriteBack);
  assign reqLatch_o = reqLatch;
  assign victimWay_o = victimPtr;
  assign hitWay_o   = wayHit_i[1];

  // line addresses with offset bits zero
  assign rdAddr_o = {reqLatch.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign wrAddr_o = {victimTag_i, index, {OFFSET_W{1'b0}}};

endmodule

// File: rtl/dcachePkg.sv
package dcachePkg;

  // cache geometry
  localparam int ADDR_W   = 32;
  localparam int XLEN     = 64;
  localparam int LINE_W   = 256;
  localparam int OFFSET_W = 5;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = 21;
  localparam int SETS     = 64;
  localparam int BEATS    = 4;
  localparam int MASK_W   = 8;

  // processor request with right-aligned data and mask
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wrData;
    logic [MASK_W-1:0] mask;
  } cpuReq_t;

  // dirty line going back to memory
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] data;
  } memWrReq_t;

  typedef enum logic [2:0] {
    Idle,
    Compare,
    WriteBack,
    Miss,
    Refill,
    Replace
  } cacheState_e;

  // way 0 or way 1
  typedef logic wayIdx_t;

endpackage

// File: rtl/dcacheTop.sv
module dcacheTop (
  input  logic                          clk,
  input  logic                          rst_n,
  input  dcachePkg::cpuReq_t            req_i,
  input  logic                          reqValid_i,
  output logic                          addrOk_o,
  output logic                          dataOk_o,
  output logic [dcachePkg::XLEN-1:0]    rdData_o,
  output logic                          rdValid_o,
  output logic [dcachePkg::ADDR_W-1:0]  rdAddr_o,
  input  logic                          rdReady_i,
  input  logic [dcachePkg::XLEN-1:0]    rdData_i,
  input  logic                          dataValid_i,
  input  logic                          rdLast_i,
  output logic                          wrValid_o,
  output dcachePkg::memWrReq_t          wrReq_o,
  input  logic                          wrReady_i
);
  import dcachePkg::*;

  cpuReq_t             reqLatch;
  logic [INDEX_W-1:0]  index;
  logic [TAG_W-1:0]    tag;
  logic [OFFSET_W-1:0] offset;
  logic [1:0]          wayHit;
  logic                victimDirty;
  logic [TAG_W-1:0]    victimTag;
  wayIdx_t             victimWay;
  wayIdx_t             hitWay;
  logic                storeEn;
  logic                fill;
  logic                refill;
  logic [ADDR_W-1:0]   wrAddr;
  logic [LINE_W-1:0]   victimLine;
  logic [LINE_W-1:0]   refillLine;

  // address fields of the request in flight
  assign offset = reqLatch.addr[OFFSET_W-1:0];
  assign index  = reqLatch.addr[OFFSET_W +: INDEX_W];
  assign tag    = reqLatch.addr[ADDR_W-1 -: TAG_W];

  assign wrReq_o.addr = wrAddr;
  assign wrReq_o.data = victimLine;

  dcacheCtrl ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .reqValid_i    (reqValid_i),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .reqLatch_o    (reqLatch),
    .wayHit_i      (wayHit),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .victimWay_o   (victimWay),
    .hitWay_o      (hitWay),
    .storeEn_o     (storeEn),
    .fill_o        (fill),
    .refill_o      (refill),
    .rdValid_o     (rdValid_o),
    .rdAddr_o      (rdAddr_o),
    .rdReady_i     (rdReady_i),
    .rdLast_i      (rdLast_i),
    .dataValid_i   (dataValid_i),
    .wrValid_o     (wrValid_o),
    .wrAddr_o      (wrAddr),
    .wrReady_i     (wrReady_i)
  );

  tagStore tags_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .index_i       (index),
    .tag_i         (tag),
    .victimWay_i   (victimWay),
    .hitWay_i      (hitWay),
    .storeEn_i     (storeEn),
    .fill_i        (fill),
    .wayHit_o      (wayHit),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dataStore data_i (
    .clk          (clk),
    .index_i      (index),
    .offset_i     (offset),
    .hitWay_i     (hitWay),
    .victimWay_i  (victimWay),
    .storeEn_i    (storeEn),
    .storeData_i  (reqLatch.wrData),
    .storeMask_i  (reqLatch.mask),
    .fill_i       (fill),
    .fillLine_i   (refillLine),
    .rdData_o     (rdData_o),
    .victimLine_o (victimLine)
  );

  refillBuffer refill_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .refill_i    (refill),
    .rdData_i    (rdData_i),
    .dataValid_i (dataValid_i),
    .rdLast_i    (rdLast_i),
    .line_o      (refillLine)
  );

endmodule

// File: rtl/refillBuffer.sv
module refillBuffer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         refill_i,
  input  logic [dcachePkg::XLEN-1:0]   rdData_i,
  input  logic                         dataValid_i,
  input  logic                         rdLast_i,
  output logic [dcachePkg::LINE_W-1:0] line_o
);
  import dcachePkg::*;

  logic [$clog2(BEATS)-1:0] beatCnt;
  logic [LINE_W-1:0]        lineBuf;

  // back to slot 0 once the last beat lands
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (refill_i && dataValid_i) begin
      beatCnt <= rdLast_i ? '0 : beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (refill_i && dataValid_i) begin
      lineBuf[beatCnt*XLEN +: XLEN] <= rdData_i;
    end
  end

  assign line_o = lineBuf;

endmodule

// File: rtl/tagStore.sv
module tagStore (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [dcachePkg::INDEX_W-1:0] index_i,
  input  logic [dcachePkg::TAG_W-1:0]   tag_i,
  input  dcachePkg::wayIdx_t            victimWay_i,
  input  dcachePkg::wayIdx_t            hitWay_i,
  input  logic                          storeEn_i,
  input  logic                          fill_i,
  output logic [1:0]                    wayHit_o,
  output logic                          victimDirty_o,
  output logic [dcachePkg::TAG_W-1:0]   victimTag_o
);
  import dcachePkg::*;

  logic [TAG_W-1:0]       tagArr [2][SETS];
  logic [1:0][SETS-1:0]   validBits;
  logic [1:0][SETS-1:0]   dirtyBits;

  // tag written together with the refilled line
  always_ff @(posedge clk) begin
    if (fill_i) begin
      tagArr[victimWay_i][index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
    end else if (fill_i) begin
      validBits[victimWay_i][index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dirtyBits <= '0;
    end else if (fill_i) begin
      dirtyBits[victimWay_i][index_i] <= 1'b0;
    end else if (storeEn_i) begin
      dirtyBits[hitWay_i][index_i] <= 1'b1;
    end
  end

  // per-way tag compare
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit_o[w] = validBits[w][index_i] && (tagArr[w][index_i] == tag_i);
    end
  end

  // dirty is only ever set on a valid line
  assign victimDirty_o = dirtyBits[victimWay_i][index_i];
  assign victimTag_o   = tagArr[victimWay_i][index_i];

endmodule

// File: run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbDcache -f filelist.f -o simDcache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simDcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tests/memModel.sv
module memModel (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         rdValid_i,
  input  logic [dcachePkg::ADDR_W-1:0] rdAddr_i,
  output logic                         rdReady_o,
  output logic [dcachePkg::XLEN-1:0]   rdData_o,
  output logic                         dataValid_o,
  output logic                         rdLast_o,
  input  logic                         wrValid_i,
  input  dcachePkg::memWrReq_t         wrReq_i,
  output logic                         wrReady_o
);
  import dcachePkg::*;

  localparam int WORDS     = 1024;
  localparam int DRIVE_DLY = 10;

  logic [XLEN-1:0] mem [WORDS];
  logic [9:0]      base;

  // random idle cycles from drive time to drive time
  task automatic randomStall(input int maxCycles);
    repeat ($urandom_range(0, maxCycles)) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  initial begin
    rdReady_o   = 1'b0;
    rdData_o    = '0;
    dataValid_o = 1'b0;
    rdLast_o    = 1'b0;
    wrReady_o   = 1'b0;
    // each word carries its own byte address
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = {32'(i * 8) ^ 32'ha5c3_0f96, ~32'(i * 8)};
    end
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      if (rst_n && wrValid_i) begin
        randomStall(3);
        wrReady_o = 1'b1;
        base      = wrReq_i.addr[12:3];
        for (int w = 0; w < BEATS; w++) begin
          mem[base + w] = wrReq_i.data[w*XLEN +: XLEN];
        end
        @(posedge clk);
        #DRIVE_DLY;
        wrReady_o = 1'b0;
      end else if (rst_n && rdValid_i) begin
        randomStall(3);
        rdReady_o = 1'b1;
        base      = rdAddr_i[12:3];
        @(posedge clk);
        #DRIVE_DLY;
        rdReady_o = 1'b0;
        // lowest word first with gaps between beats
        for (int b = 0; b < BEATS; b++) begin
          randomStall(2);
          dataValid_o = 1'b1;
          rdLast_o    = (b == BEATS - 1);
          rdData_o    = mem[base + b];
          @(posedge clk);
          #DRIVE_DLY;
          dataValid_o = 1'b0;
          rdLast_o    = 1'b0;
        end
      end
    end
  end

endmodule

// File: tests/tbDcache.sv
module tbDcache;
  import dcachePkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;
  localparam int WAIT_LIMIT = 200;
  localparam int SOAK_OPS   = 300;

  logic              clk;
  logic              rst_n;
  cpuReq_t           req;
  logic              reqValid;
  logic              addrOk;
  logic              dataOk;
  logic [XLEN-1:0]   rdData;
  logic              rdValid;
  logic [ADDR_W-1:0] rdAddr;
  logic              rdReady;
  logic [XLEN-1:0]   memData;
  logic              dataValid;
  logic              rdLast;
  logic              wrValid;
  memWrReq_t         wrReq;
  logic              wrReady;

  // shadow of the 8 KB the tests touch
  logic [XLEN-1:0]   shadow [1024];
  // expected responses with a store flag on top
  logic [XLEN:0]     expQ [$];
  // memory handshakes with a write-back flag on top
  logic [ADDR_W:0]   memEvents [$];
  logic [XLEN:0]     expEntry;
  int                errors;
  int                checks;
  int                lastLatency;

  dcacheTop dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req),
    .reqValid_i  (reqValid),
    .addrOk_o    (addrOk),
    .dataOk_o    (dataOk),
    .rdData_o    (rdData),
    .rdValid_o   (rdValid),
    .rdAddr_o    (rdAddr),
    .rdReady_i   (rdReady),
    .rdData_i    (memData),
    .dataValid_i (dataValid),
    .rdLast_i    (rdLast),
    .wrValid_o   (wrValid),
    .wrReq_o     (wrReq),
    .wrReady_i   (wrReady)
  );

  memModel mem_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdValid_i   (rdValid),
    .rdAddr_i    (rdAddr),
    .rdReady_o   (rdReady),
    .rdData_o    (memData),
    .dataValid_o (dataValid),
    .rdLast_o    (rdLast),
    .wrValid_i   (wrValid),
    .wrReq_i     (wrReq),
    .wrReady_o   (wrReady)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [XLEN-1:0] refLoad(input logic [ADDR_W-1:0] addr);
    return shadow[addr[12:3]];
  endfunction

  // byte lanes move up by the offset and drop past byte 7
  function automatic void applyStore(input logic [ADDR_W-1:0] addr,
                                     input logic [XLEN-1:0] data,
                                     input logic [MASK_W-1:0] mask);
    int src;
    for (int b = 0; b < MASK_W; b++) begin
      src = b - int'(addr[2:0]);
      if (src >= 0) begin
        if (mask[src]) begin
          shadow[addr[12:3]][b*8 +: 8] = data[src*8 +: 8];
        end
      end
    end
  endfunction

  task automatic finishRun();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic runAccess(input logic wr, input logic [ADDR_W-1:0] addr,
                           input logic [XLEN-1:0] data, input logic [MASK_W-1:0] mask);
    int cnt;
    cnt = 0;
    while (!addrOk && cnt < WAIT_LIMIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      cnt++;
    end
    if (!addrOk) begin
      errors++;
      $display("timed out waiting for addrOk_o");
      finishRun();
    end else begin
      expQ.push_back({wr, refLoad(addr)});
      if (wr) begin
        applyStore(addr, data, mask);
      end
      req      = '{wr, addr, data, mask};
      reqValid = 1'b1;
      @(posedge clk);
      #DRIVE_DLY;
      reqValid = 1'b0;
      cnt      = 0;
      while (!dataOk && cnt < WAIT_LIMIT) begin
        @(posedge clk);
        #DRIVE_DLY;
        cnt++;
      end
      if (!dataOk) begin
        errors++;
        $display("timed out waiting for dataOk_o at address %h", addr);
        finishRun();
      end else begin
        lastLatency = cnt;
      end
    end
  endtask

  // one request plus the memory traffic it must cause
  task automatic directedStep(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [XLEN-1:0] data, input logic [MASK_W-1:0] mask,
                              input logic expWr, input logic [ADDR_W-1:0] wbLine,
                              input logic expRd);
    int mark;
    int n;
    mark = memEvents.size();
    runAccess(wr, addr, data, mask);
    n = memEvents.size() - mark;
    checks++;
    assert (n == int'(expWr) + int'(expRd)) else begin
      errors++;
      $display("request at %h caused %0d memory requests instead of %0d", addr, n,
               int'(expWr) + int'(expRd));
    end
    if (expWr && n > 0) begin
      checks++;
      assert (memEvents[mark] == {1'b1, wbLine}) else begin
        errors++;
        $display("[ERROR] wrReq_o.addr: got %h, expected %h", memEvents[mark], {1'b1, wbLine});
      end
    end
    if (expRd && n == int'(expWr) + 1) begin
      checks++;
      assert (memEvents[mark + n - 1] == {1'b0, addr[31:5], 5'b0}) else begin
        errors++;
        $display("[ERROR] rdAddr_o: got %h, expected %h", memEvents[mark + n - 1],
                 {1'b0, addr[31:5], 5'b0});
      end
    end
  endtask

  // responses and write-backs against the shadow
  always @(negedge clk) begin
    if (rst_n) begin
      if (rdValid && rdReady) begin
        memEvents.push_back({1'b0, rdAddr});
      end
      if (wrValid && wrReady) begin
        memEvents.push_back({1'b1, wrReq.addr});
        for (int w = 0; w < BEATS; w++) begin
          checks++;
          assert (wrReq.data[w*XLEN +: XLEN] == shadow[wrReq.addr[12:3] + w]) else begin
            errors++;
            $display("[ERROR] wrReq_o.data word %0d: got %h, expected %h", w,
                     wrReq.data[w*XLEN +: XLEN], shadow[wrReq.addr[12:3] + w]);
          end
        end
      end
      if (dataOk) begin
        checks++;
        assert (expQ.size() > 0) else begin
          errors++;
          $display("dataOk_o pulsed with no request in flight");
        end
        if (expQ.size() > 0) begin
          expEntry = expQ.pop_front();
          if (!expEntry[XLEN]) begin
            checks++;
            assert (rdData == expEntry[XLEN-1:0]) else begin
              errors++;
              $display("[ERROR] rdData_o: got %h, expected %h", rdData, expEntry[XLEN-1:0]);
            end
          end
        end
      end
    end
  end

  initial begin
    logic [ADDR_W-1:0] soakAddr;
    void'($urandom(32'h9b7f_9936));
    errors      = 0;
    checks      = 0;
    lastLatency = 0;
    rst_n       = 1'b0;
    reqValid    = 1'b0;
    req         = '0;
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = {32'(i * 8) ^ 32'ha5c3_0f96, ~32'(i * 8)};
    end
    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    checks++;
    assert ({addrOk, dataOk, rdValid, wrValid} == 4'b1000) else begin
      errors++;
      $display("[ERROR] addrOk_o,dataOk_o,rdValid_o,wrValid_o after reset: got %h, expected %h",
               {addrOk, dataOk, rdValid, wrValid}, 4'b1000);
    end

    // cold miss and then a hit on the same line
    directedStep(1'b0, 32'h0000_0048, '0, '0, 1'b0, '0, 1'b1);
    directedStep(1'b0, 32'h0000_0058, '0, '0, 1'b0, '0, 1'b0);
    checks++;
    assert (lastLatency == 0) else begin
      errors++;
      $display("load hit answered %0d cycles late", lastLatency);
    end
    // masked stores where the second one spills past the word end
    directedStep(1'b1, 32'h0000_0043, 64'h1122_3344_5566_7788, 8'h06, 1'b0, '0, 1'b0);
    directedStep(1'b1, 32'h0000_004d, 64'h99aa_bbcc_ddee_f001, 8'hff, 1'b0, '0, 1'b0);
    directedStep(1'b0, 32'h0000_0040, '0, '0, 1'b0, '0, 1'b0);
    directedStep(1'b0, 32'h0000_0048, '0, '0, 1'b0, '0, 1'b0);
    // three tags in set 2 evicted round-robin even after a hit on A
    directedStep(1'b0, 32'h0000_0848, '0, '0, 1'b0, '0, 1'b1);
    directedStep(1'b0, 32'h0000_0050, '0, '0, 1'b0, '0, 1'b0);
    directedStep(1'b0, 32'h0000_1048, '0, '0, 1'b1, 32'h0000_0040, 1'b1);
    directedStep(1'b0, 32'h0000_0048, '0, '0, 1'b0, '0, 1'b1);
    directedStep(1'b1, 32'h0000_0850, 64'h0123_4567_89ab_cdef, 8'hf0, 1'b0, '0, 1'b1);
    directedStep(1'b0, 32'h0000_1040, '0, '0, 1'b0, '0, 1'b1);
    directedStep(1'b0, 32'h0000_0040, '0, '0, 1'b1, 32'h0000_0840, 1'b1);

    // random soak over 8 KB with four tags per set
    for (int i = 0; i < SOAK_OPS; i++) begin
      soakAddr = 32'($urandom_range(0, 8191));
      if ($urandom_range(0, 1) == 1) begin
        runAccess(1'b1, soakAddr, {$urandom, $urandom}, 8'($urandom));
      end else begin
        runAccess(1'b0, soakAddr, '0, '0);
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
    checks++;
    assert (expQ.size() == 0) else begin
      errors++;
      $display("%0d requests ended without dataOk_o", expQ.size());
    end
    finishRun();
  end

endmodule
